//--- design/decode_pkg.sv
package decode_pkg;

	// RV32 major opcodes
	localparam logic [6:0] OPC_LUI    = 7'h37;
	localparam logic [6:0] OPC_AUIPC  = 7'h17;
	localparam logic [6:0] OPC_JAL    = 7'h6f;
	localparam logic [6:0] OPC_JALR   = 7'h67;
	localparam logic [6:0] OPC_BRANCH = 7'h63;
	localparam logic [6:0] OPC_LOAD   = 7'h03;
	localparam logic [6:0] OPC_STORE  = 7'h23;
	localparam logic [6:0] OPC_OP_IMM = 7'h13;
	localparam logic [6:0] OPC_OP     = 7'h33;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9,
		ALU_LUI  = 4'd10	// Op B straight through
	} alu_op_e;

	// Write-back source
	typedef enum logic [2:0] {
		SEL_PC4  = 3'd0,
		SEL_ALU  = 3'd1,
		SEL_IMM  = 3'd2,
		SEL_LOAD = 3'd3,
		SEL_DIV  = 3'd4
	} sel_data_e;

	typedef enum logic [2:0] {
		DM_LB   = 3'd0,
		DM_LH   = 3'd1,
		DM_LW   = 3'd2,
		DM_LBU  = 3'd3,
		DM_LHU  = 3'd4,
		DM_NONE = 3'd7		// No load in flight
	} dm_select_e;

	typedef enum logic [1:0] {
		ST_SB = 2'd0,
		ST_SH = 2'd1,
		ST_SW = 2'd2
	} store_select_e;

	// Base view of the fetched word
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} base_fmt_t;

	// RVC view, low halfword only
	typedef struct packed {
		logic [15:0] upper;		// Next parcel, ignored
		logic [2:0]  funct3;
		logic [10:0] mid;		// Registers and immediate bits
		logic [1:0]  quad;		// Quadrant, 2'b11 means base word
	} comp_fmt_t;

	typedef union packed {
		base_fmt_t base;
		comp_fmt_t comp;
	} inst_word_u;

	typedef struct packed {
		alu_op_e       alu_op;
		logic          sel_op_a;	// 1 = rs1, 0 = PC
		logic          sel_op_b;	// 1 = imm, 0 = rs2
		logic          sel_op_br;	// Target base from rs1
		logic          is_stype;
		logic          is_jump;
		logic          is_btype;
		logic          sel_pc;		// Redirect fetch to target
		logic          wr_en;
		dm_select_e    dm_select;
		store_select_e store_select;
		sel_data_e     sel_data;
		logic          div_valid;
		logic [1:0]    div_op;		// DIV, DIVU, REM, REMU
	} ctrl_t;

	typedef struct packed {
		ctrl_t       ctrl;
		logic [4:0]  rs_a;
		logic [4:0]  rs_b;
		logic [4:0]  rd;
		logic [31:0] imm;
		logic [31:0] jt;		// Jump or branch offset
		logic        illegal;
		logic        is_comp;
	} decode_t;

	// Bubble controls, every enable off
	localparam ctrl_t CTRL_IDLE = '{
		alu_op: ALU_ADD, sel_op_a: 1'b0, sel_op_b: 1'b0, sel_op_br: 1'b0,
		is_stype: 1'b0, is_jump: 1'b0, is_btype: 1'b0, sel_pc: 1'b0, wr_en: 1'b0,
		dm_select: DM_NONE, store_select: ST_SW, sel_data: SEL_ALU,
		div_valid: 1'b0, div_op: 2'd0
	};

endpackage

//--- design/base_decoder.sv
`timescale 1ns/1ps

module base_decoder (
	input  decode_pkg::inst_word_u inst,	// Fetched word
	output decode_pkg::decode_t    dec		// RV32IM decode record
);
	import decode_pkg::*;

	base_fmt_t   w;			// Field view
	logic [31:0] raw;		// Flat bits for immediate shuffles
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	// funct3 to ALU lane, alt picks SUB or SRA
	function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign w   = inst.base;
	assign raw = inst;

	assign imm_i = {{20{raw[31]}}, raw[31:20]};
	assign imm_s = {{20{raw[31]}}, raw[31:25], raw[11:7]};
	assign imm_b = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
	assign imm_u = {raw[31:12], 12'b0};
	assign imm_j = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};

	always_comb begin
		dec      = '0;
		dec.ctrl = CTRL_IDLE;
		dec.rs_a = w.rs1;	// Raw fields, unused ones are harmless
		dec.rs_b = w.rs2;
		dec.rd   = w.rd;
		case (w.opcode)
			OPC_LUI: begin
				dec.ctrl.wr_en    = 1'b1;
				dec.ctrl.sel_op_b = 1'b1;
				dec.ctrl.alu_op   = ALU_LUI;
				dec.ctrl.sel_data = SEL_IMM;
				dec.imm           = imm_u;
			end
			OPC_AUIPC: begin
				dec.ctrl.wr_en    = 1'b1;
				dec.ctrl.sel_op_b = 1'b1;	// PC + imm
				dec.imm           = imm_u;
			end
			OPC_JAL, OPC_JALR: begin
				dec.ctrl.wr_en    = 1'b1;
				dec.ctrl.is_jump  = 1'b1;
				dec.ctrl.sel_pc   = 1'b1;
				dec.ctrl.sel_data = SEL_PC4;		// Link value
				if (w.opcode == OPC_JAL) begin
					dec.imm = imm_j;
					dec.jt  = imm_j;
				end else begin
					dec.imm            = imm_i;
					dec.ctrl.sel_op_a  = 1'b1;
					dec.ctrl.sel_op_br = 1'b1;	// rs1 + imm
					dec.illegal        = (w.funct3 != 3'b000);
				end
			end
			OPC_BRANCH: begin
				dec.ctrl.is_btype = 1'b1;
				dec.ctrl.sel_op_a = 1'b1;
				dec.imm           = imm_b;
				dec.jt            = imm_b;
				// Compare lane by branch kind
				dec.ctrl.alu_op   = w.funct3[2] ? (w.funct3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
				dec.illegal       = (w.funct3[2:1] == 2'b01);
			end
			OPC_LOAD: begin
				dec.ctrl.wr_en    = 1'b1;
				dec.ctrl.sel_op_a = 1'b1;
				dec.ctrl.sel_op_b = 1'b1;
				dec.ctrl.sel_data = SEL_LOAD;
				dec.imm           = imm_i;
				case (w.funct3)
					3'b000:  dec.ctrl.dm_select = DM_LB;
					3'b001:  dec.ctrl.dm_select = DM_LH;
					3'b010:  dec.ctrl.dm_select = DM_LW;
					3'b100:  dec.ctrl.dm_select = DM_LBU;
					3'b101:  dec.ctrl.dm_select = DM_LHU;
					default: dec.illegal = 1'b1;
				endcase
			end
			OPC_STORE: begin
				dec.ctrl.is_stype = 1'b1;
				dec.ctrl.sel_op_a = 1'b1;
				dec.ctrl.sel_op_b = 1'b1;	// Address = rs1 + imm
				dec.imm           = imm_s;
				case (w.funct3)
					3'b000:  dec.ctrl.store_select = ST_SB;
					3'b001:  dec.ctrl.store_select = ST_SH;
					3'b010:  dec.ctrl.store_select = ST_SW;
					default: dec.illegal = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				dec.ctrl.wr_en    = 1'b1;
				dec.ctrl.sel_op_a = 1'b1;
				dec.ctrl.sel_op_b = 1'b1;
				dec.imm           = imm_i;
				dec.ctrl.alu_op   = alu_from_f3(w.funct3, (w.funct3 == 3'b101) & w.funct7[5]);
				// Shift amounts carry a funct7 of their own
				if (w.funct3 == 3'b001 && w.funct7 != 7'h00)
					dec.illegal = 1'b1;
				if (w.funct3 == 3'b101 && w.funct7 != 7'h00 && w.funct7 != 7'h20)
					dec.illegal = 1'b1;
			end
			OPC_OP: begin
				dec.ctrl.wr_en    = 1'b1;
				dec.ctrl.sel_op_a = 1'b1;
				case (w.funct7)
					7'h00: dec.ctrl.alu_op = alu_from_f3(w.funct3, 1'b0);
					7'h20: begin
						dec.ctrl.alu_op = alu_from_f3(w.funct3, 1'b1);
						dec.illegal     = (w.funct3 != 3'b000) && (w.funct3 != 3'b101);
					end
					7'h01: begin
						// Only the divide half of M, multiplies fall out
						dec.ctrl.div_valid = w.funct3[2];
						dec.ctrl.div_op    = w.funct3[1:0];
						dec.ctrl.sel_data  = SEL_DIV;
						dec.illegal        = !w.funct3[2];
					end
					default: dec.illegal = 1'b1;
				endcase
			end
			default: dec.illegal = 1'b1;
		endcase
		if (dec.illegal)
			dec.ctrl = CTRL_IDLE;	// Bubble
	end

endmodule

//--- design/compressed_decoder.sv
`timescale 1ns/1ps

module compressed_decoder (
	input  decode_pkg::inst_word_u inst,	// Fetched word, low half used
	output decode_pkg::decode_t    dec		// Expanded decode record
);
	import decode_pkg::*;

	comp_fmt_t   cw;
	logic [15:0] c;				// The RVC parcel
	logic [4:0]  r_full;		// rd/rs1 in [11:7]
	logic [4:0]  r_src2;		// rs2 in [6:2]
	logic [4:0]  r_hi_p;		// rs1' in [9:7]
	logic [4:0]  r_lo_p;		// rd'/rs2' in [4:2]
	logic [31:0] imm6;			// Signed, bit 12 and [6:2]
	logic [31:0] uimm_spn;		// C.ADDI4SPN scaled by 4
	logic [31:0] uimm_lsw;		// C.LW / C.SW offset
	logic [31:0] off_cj;		// CJ format
	logic [31:0] off_cb;		// CB format

	assign cw = inst.comp;
	assign c  = {cw.funct3, cw.mid, cw.quad};

	assign r_full = c[11:7];
	assign r_src2 = c[6:2];
	assign r_hi_p = {2'b01, c[9:7]};	// x8..x15
	assign r_lo_p = {2'b01, c[4:2]};

	assign imm6     = {{26{c[12]}}, c[12], c[6:2]};
	assign uimm_spn = {22'b0, c[10:7], c[12:11], c[5], c[6], 2'b00};
	assign uimm_lsw = {25'b0, c[5], c[12:10], c[6], 2'b00};
	assign off_cj   = {{20{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
	assign off_cb   = {{23{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};

	always_comb begin
		dec      = '0;
		dec.ctrl = CTRL_IDLE;
		case ({cw.quad, cw.funct3})
			5'b00_000: begin		// C.ADDI4SPN
				dec.rd            = r_lo_p;
				dec.rs_a          = 5'd2;	// sp
				dec.imm           = uimm_spn;
				dec.ctrl.wr_en    = 1'b1;
				dec.ctrl.sel_op_a = 1'b1;
				dec.ctrl.sel_op_b = 1'b1;
				dec.illegal       = (uimm_spn == '0);	// Also catches the zero word
			end
			5'b00_010: begin		// C.LW
				dec.rd             = r_lo_p;
				dec.rs_a           = r_hi_p;
				dec.imm            = uimm_lsw;
				dec.ctrl.wr_en     = 1'b1;
				dec.ctrl.sel_op_a  = 1'b1;
				dec.ctrl.sel_op_b  = 1'b1;
				dec.ctrl.dm_select = DM_LW;
				dec.ctrl.sel_data  = SEL_LOAD;
			end
			5'b00_110: begin		// C.SW
				dec.rs_a              = r_hi_p;
				dec.rs_b              = r_lo_p;
				dec.imm               = uimm_lsw;
				dec.ctrl.is_stype     = 1'b1;
				dec.ctrl.sel_op_a     = 1'b1;
				dec.ctrl.sel_op_b     = 1'b1;
				dec.ctrl.store_select = ST_SW;
			end
			5'b01_000, 5'b01_010: begin	// C.ADDI, C.LI
				dec.rd            = r_full;
				dec.rs_a          = cw.funct3[1] ? 5'd0 : r_full;	// C.LI adds to x0
				dec.imm           = imm6;
				dec.ctrl.wr_en    = 1'b1;
				dec.ctrl.sel_op_a = 1'b1;
				dec.ctrl.sel_op_b = 1'b1;
			end
			5'b01_001, 5'b01_101: begin	// C.JAL, C.J
				dec.rd            = cw.funct3[2] ? 5'd0 : 5'd1;	// C.J links to x0
				dec.imm           = off_cj;
				dec.jt            = off_cj;
				dec.ctrl.wr_en    = 1'b1;
				dec.ctrl.is_jump  = 1'b1;
				dec.ctrl.sel_pc   = 1'b1;
				dec.ctrl.sel_data = SEL_PC4;
			end
			5'b01_011: begin		// C.LUI
				dec.rd            = r_full;
				dec.imm           = {imm6[19:0], 12'b0};
				dec.ctrl.wr_en    = 1'b1;
				dec.ctrl.sel_op_b = 1'b1;
				dec.ctrl.alu_op   = ALU_LUI;
				dec.ctrl.sel_data = SEL_IMM;
				// rd = sp is C.ADDI16SP, not in the subset
				dec.illegal       = (r_full == 5'd0) || (r_full == 5'd2) || (imm6 == '0);
			end
			5'b01_110, 5'b01_111: begin	// C.BEQZ, C.BNEZ
				dec.rs_a          = r_hi_p;
				dec.rs_b          = 5'd0;	// Compare with x0
				dec.imm           = off_cb;
				dec.jt            = off_cb;
				dec.ctrl.is_btype = 1'b1;
				dec.ctrl.sel_op_a = 1'b1;
				dec.ctrl.alu_op   = ALU_SUB;
			end
			5'b10_000: begin		// C.SLLI
				dec.rd            = r_full;
				dec.rs_a          = r_full;
				dec.imm           = {27'b0, c[6:2]};
				dec.ctrl.wr_en    = 1'b1;
				dec.ctrl.sel_op_a = 1'b1;
				dec.ctrl.sel_op_b = 1'b1;
				dec.ctrl.alu_op   = ALU_SLL;
				dec.illegal       = c[12];	// shamt[5] reserved on RV32
			end
			5'b10_100: begin
				dec.ctrl.sel_op_a = 1'b1;
				if (r_src2 == 5'd0) begin
					// C.JR or C.JALR, target is rs1 alone
					dec.rd             = c[12] ? 5'd1 : 5'd0;
					dec.rs_a           = r_full;
					dec.ctrl.wr_en     = 1'b1;
					dec.ctrl.is_jump   = 1'b1;
					dec.ctrl.sel_pc    = 1'b1;
					dec.ctrl.sel_op_br = 1'b1;
					dec.ctrl.sel_data  = SEL_PC4;
					dec.illegal        = (r_full == 5'd0);	// Reserved or C.EBREAK
				end else begin
					// C.MV adds to x0, C.ADD adds to rd
					dec.rd         = r_full;
					dec.rs_a       = c[12] ? r_full : 5'd0;
					dec.rs_b       = r_src2;
					dec.ctrl.wr_en = 1'b1;
				end
			end
			default: dec.illegal = 1'b1;	// Outside the subset or a base word
		endcase
		if (dec.illegal)
			dec.ctrl = CTRL_IDLE;
	end

endmodule

//--- design/decode_select.sv
`timescale 1ns/1ps

module decode_select #(
	parameter int PC_W = 12		// PC width
) (
	input  decode_pkg::decode_t base_dec,	// From the RV32IM decoder
	input  decode_pkg::decode_t comp_dec,	// From the RVC decoder
	input  logic [1:0]          quadrant,	// Low two bits of the word
	input  logic [PC_W-1:0]     pc,
	input  logic [31:0]         rs1_data,	// Register base for JALR style jumps
	output decode_pkg::decode_t id_dec,
	output logic [PC_W-1:0]     id_pc4,		// Next sequential PC
	output logic [PC_W-1:0]     id_target	// Jump or branch target
);

	logic        is_comp;
	logic        use_reg;		// Register based target
	logic [31:0] pc_ext;
	logic [31:0] br_base;
	logic [31:0] br_off;
	logic [31:0] target_full;

	// Anything not ending in 2'b11 is a 16-bit word
	assign is_comp = (quadrant != 2'b11);

	always_comb begin
		id_dec         = is_comp ? comp_dec : base_dec;
		id_dec.is_comp = is_comp;
	end

	// Half step for RVC
	assign id_pc4 = pc + (is_comp ? PC_W'(2) : PC_W'(4));

	assign use_reg = id_dec.ctrl.sel_op_br;
	assign pc_ext  = 32'(pc);
	assign br_base = use_reg ? rs1_data : pc_ext;

	// C.JR and C.JALR add nothing
	always_comb begin
		if (is_comp)
			br_off = use_reg ? 32'd0 : comp_dec.jt;
		else
			br_off = base_dec.imm;
	end

	assign target_full = br_base + br_off;
	assign id_target   = target_full[PC_W-1:0];	// Wraps to the fetch space

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
	parameter int PC_W = 12		// Fetch address width
) (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  logic                   inst_valid,	// One word per strobe
	input  decode_pkg::inst_word_u inst,
	input  logic [PC_W-1:0]        pc,			// Address of inst
	input  logic [31:0]            rs1_data,	// rs1 value for register jumps
	output logic                   exe_valid,
	output decode_pkg::decode_t    exe_dec,
	output logic [PC_W-1:0]        exe_pc4,
	output logic [PC_W-1:0]        exe_target
);
	import decode_pkg::*;

	decode_t         base_dec;
	decode_t         comp_dec;
	decode_t         id_dec;		// Chosen record
	logic [PC_W-1:0] id_pc4;
	logic [PC_W-1:0] id_target;

	// Both decoders see every word
	base_decoder i_base_decoder (
		.inst (inst),
		.dec  (base_dec)
	);

	compressed_decoder i_compressed_decoder (
		.inst (inst),
		.dec  (comp_dec)
	);

	decode_select #(
		.PC_W (PC_W)
	) i_decode_select (
		.base_dec  (base_dec),
		.comp_dec  (comp_dec),
		.quadrant  (inst.comp.quad),
		.pc        (pc),
		.rs1_data  (rs1_data),
		.id_dec    (id_dec),
		.id_pc4    (id_pc4),
		.id_target (id_target)
	);

	// ID/EXE register
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			exe_valid    <= 1'b0;
			exe_dec.ctrl <= CTRL_IDLE;	// No write-back out of reset
		end else begin
			exe_valid <= inst_valid;	// Drops on idle cycles
			if (inst_valid) begin
				exe_dec    <= id_dec;
				exe_pc4    <= id_pc4;
				exe_target <= id_target;
			end
		end
	end

endmodule

//--- tests/decode_stage_checker.sv
`timescale 1ns/1ps

module decode_stage_checker #(
	parameter int PC_W = 12
) (
	input logic                CLK,
	input logic                rst_n,
	input logic                inst_valid,
	input logic [PC_W-1:0]     pc,
	input logic                exe_valid,
	input decode_pkg::decode_t exe_dec,
	input logic [PC_W-1:0]     exe_pc4
);

	logic [PC_W-1:0] pc_q;		// pc of the word now in ID/EXE

	always_ff @(posedge CLK) begin
		if (!rst_n)
			pc_q <= '0;
		else if (inst_valid)
			pc_q <= pc;
	end

	// Sync reset, so valid drops one edge later
	reset_clears_valid: assert property (@(posedge CLK) !rst_n |=> !exe_valid)
		else $error("exe_valid high after a reset cycle");

	illegal_is_bubble: assert property (@(posedge CLK) disable iff (!rst_n)
		exe_valid && exe_dec.illegal |->
			!exe_dec.ctrl.wr_en && !exe_dec.ctrl.is_jump && !exe_dec.ctrl.div_valid)
		else $error("Illegal word left an enable set");

	store_no_write: assert property (@(posedge CLK) disable iff (!rst_n)
		exe_valid && exe_dec.ctrl.is_stype |-> !exe_dec.ctrl.wr_en)
		else $error("Store word with wr_en set");

	// Half step exactly for RVC words
	step_matches_size: assert property (@(posedge CLK) disable iff (!rst_n)
		exe_valid |-> (((exe_pc4 - pc_q) == PC_W'(2)) == exe_dec.is_comp))
		else $error("Sequential PC step disagrees with is_comp");

endmodule

//--- tests/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;
	import decode_pkg::*;

	localparam int PC_W = 12;

	// One table row, stimulus then expected values
	typedef struct packed {
		inst_word_u      inst;
		logic [PC_W-1:0] pc;
		logic [31:0]     rs1_data;
		logic [4:0]      rd;
		logic [4:0]      rs_a;
		logic [4:0]      rs_b;
		logic [31:0]     imm;
		logic            wr_en;
		sel_data_e       sel_data;
		logic            is_comp;
		logic            illegal;
		logic [PC_W-1:0] pc4;
		logic [PC_W-1:0] target;
	} vector_t;

	logic            CLK;
	logic            rst_n;
	logic            inst_valid;
	inst_word_u      inst;
	logic [PC_W-1:0] pc;
	logic [31:0]     rs1_data;
	logic            exe_valid;
	decode_t         exe_dec;
	logic [PC_W-1:0] exe_pc4;
	logic [PC_W-1:0] exe_target;

	vector_t     vectors[$];
	string       names[$];
	logic [31:0] lfsr = 32'heb21_2d1f;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          limit = 0;		// Cycle budget, known once the table is loaded

	decode_stage #(
		.PC_W (PC_W)
	) i_decode_stage (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.pc         (pc),
		.rs1_data   (rs1_data),
		.exe_valid  (exe_valid),
		.exe_dec    (exe_dec),
		.exe_pc4    (exe_pc4),
		.exe_target (exe_target)
	);

	bind decode_stage decode_stage_checker #(
		.PC_W (PC_W)
	) i_decode_stage_checker (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.pc         (pc),
		.exe_valid  (exe_valid),
		.exe_dec    (exe_dec),
		.exe_pc4    (exe_pc4)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;		// 20 ns period
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_gap(output int gap);
		gap = 0;
		repeat (2) begin		// One step per bit
			lfsr = lfsr_step(lfsr);
			gap  = gap * 2 + int'(lfsr[0]);
		end
	endtask

	task automatic add_vector(input string name, input logic [31:0] word,
			input logic [PC_W-1:0] at_pc, input logic [31:0] rs1,
			input logic [4:0] rd, input logic [4:0] rs_a, input logic [4:0] rs_b,
			input logic [31:0] imm, input logic wr_en, input sel_data_e sel_data,
			input logic is_comp, input logic illegal,
			input logic [PC_W-1:0] pc4, input logic [PC_W-1:0] target);
		vector_t v;
		v = {word, at_pc, rs1, rd, rs_a, rs_b, imm, wr_en, sel_data, is_comp, illegal,
			pc4, target};
		vectors.push_back(v);
		names.push_back(name);
	endtask

	task automatic load_table();
		// Base words, step of 4
		add_vector("ADD", 32'h002081b3, 12'h100, 32'h0,
			5'd3, 5'd1, 5'd2, 32'h0, 1'b1, SEL_ALU, 1'b0, 1'b0, 12'h104, 12'h100);
		add_vector("ADDI", 32'hffd30293, 12'h200, 32'h0,
			5'd5, 5'd6, 5'd29, 32'hffff_fffd, 1'b1, SEL_ALU, 1'b0, 1'b0, 12'h204, 12'h1fd);
		add_vector("LW", 32'h00852383, 12'h300, 32'h0,
			5'd7, 5'd10, 5'd8, 32'h8, 1'b1, SEL_LOAD, 1'b0, 1'b0, 12'h304, 12'h308);
		add_vector("SW", 32'h00b62623, 12'h400, 32'h0,
			5'd12, 5'd12, 5'd11, 32'hc, 1'b0, SEL_ALU, 1'b0, 1'b0, 12'h404, 12'h40c);
		add_vector("LUI", 32'h123454b7, 12'h500, 32'h0,
			5'd9, 5'd8, 5'd3, 32'h1234_5000, 1'b1, SEL_IMM, 1'b0, 1'b0, 12'h504, 12'h500);
		add_vector("DIV", 32'h02f746b3, 12'h600, 32'h0,
			5'd13, 5'd14, 5'd15, 32'h0, 1'b1, SEL_DIV, 1'b0, 1'b0, 12'h604, 12'h600);
		add_vector("JAL_FWD", 32'h100000ef, 12'h7f0, 32'h0,
			5'd1, 5'd0, 5'd0, 32'h100, 1'b1, SEL_PC4, 1'b0, 1'b0, 12'h7f4, 12'h8f0);
		add_vector("JAL_WRAP", 32'hff1ff06f, 12'h008, 32'h0,	// Target below zero
			5'd0, 5'd31, 5'd17, 32'hffff_fff0, 1'b1, SEL_PC4, 1'b0, 1'b0, 12'h00c, 12'hff8);
		add_vector("BEQ", 32'h00208463, 12'h800, 32'h0,
			5'd8, 5'd1, 5'd2, 32'h8, 1'b0, SEL_ALU, 1'b0, 1'b0, 12'h804, 12'h808);
		add_vector("JALR", 32'h010280e7, 12'h900, 32'h1234,
			5'd1, 5'd5, 5'd16, 32'h10, 1'b1, SEL_PC4, 1'b0, 1'b0, 12'h904, 12'h244);
		// RVC words, step of 2
		add_vector("C.ADDI", 32'hffff157d, 12'ha00, 32'h0,	// Upper half is noise
			5'd10, 5'd10, 5'd0, 32'hffff_ffff, 1'b1, SEL_ALU, 1'b1, 1'b0, 12'ha02, 12'ha00);
		add_vector("C.LI", 32'h00004615, 12'h010, 32'h0,
			5'd12, 5'd0, 5'd0, 32'h5, 1'b1, SEL_ALU, 1'b1, 1'b0, 12'h012, 12'h010);
		add_vector("C.LW", 32'h00004044, 12'hb00, 32'h0,
			5'd9, 5'd8, 5'd0, 32'h4, 1'b1, SEL_LOAD, 1'b1, 1'b0, 12'hb02, 12'hb00);
		add_vector("C.SW", 32'h0000c588, 12'hc00, 32'h0,
			5'd0, 5'd11, 5'd10, 32'h8, 1'b0, SEL_ALU, 1'b1, 1'b0, 12'hc02, 12'hc00);
		add_vector("C.MV", 32'h0000829a, 12'hd00, 32'h0,
			5'd5, 5'd0, 5'd6, 32'h0, 1'b1, SEL_ALU, 1'b1, 1'b0, 12'hd02, 12'hd00);
		add_vector("C.ADDI4SPN", 32'h00000800, 12'he00, 32'h0,
			5'd8, 5'd2, 5'd0, 32'h10, 1'b1, SEL_ALU, 1'b1, 1'b0, 12'he02, 12'he00);
		add_vector("C.JAL", 32'h00002801, 12'h020, 32'h0,
			5'd1, 5'd0, 5'd0, 32'h10, 1'b1, SEL_PC4, 1'b1, 1'b0, 12'h022, 12'h030);
		add_vector("C.J", 32'h0000bff5, 12'h002, 32'h0,
			5'd0, 5'd0, 5'd0, 32'hffff_fffc, 1'b1, SEL_PC4, 1'b1, 1'b0, 12'h004, 12'hffe);
		add_vector("C.BNEZ", 32'h0000e099, 12'hf00, 32'h0,
			5'd0, 5'd9, 5'd0, 32'h6, 1'b0, SEL_ALU, 1'b1, 1'b0, 12'hf02, 12'hf06);
		add_vector("C.JR", 32'h00008382, 12'h0f0, 32'habc,
			5'd0, 5'd7, 5'd0, 32'h0, 1'b1, SEL_PC4, 1'b1, 1'b0, 12'h0f2, 12'habc);
		// Unsupported words
		add_vector("ZERO_WORD", 32'h00000000, 12'h124, 32'h0,
			5'd8, 5'd2, 5'd0, 32'h0, 1'b0, SEL_ALU, 1'b1, 1'b1, 12'h126, 12'h124);
		add_vector("BAD_OPCODE", 32'h0000007f, 12'h130, 32'h0,
			5'd0, 5'd0, 5'd0, 32'h0, 1'b0, SEL_ALU, 1'b0, 1'b1, 12'h134, 12'h130);
	endtask

	task automatic report_mismatch(input string test, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		$display("Error %s: %s expected %h, actual %h", test, field, expected, actual);
		errors++;
	endtask

	task automatic check_outputs(input int n);
		vector_t e;
		e = vectors[n];
		checks++;
		if (exe_valid !== 1'b1)
			report_mismatch(names[n], "exe_valid", 32'd1, 32'(exe_valid));
		if (exe_dec.rd !== e.rd)
			report_mismatch(names[n], "rd", 32'(e.rd), 32'(exe_dec.rd));
		if (exe_dec.rs_a !== e.rs_a)
			report_mismatch(names[n], "rs_a", 32'(e.rs_a), 32'(exe_dec.rs_a));
		if (exe_dec.rs_b !== e.rs_b)
			report_mismatch(names[n], "rs_b", 32'(e.rs_b), 32'(exe_dec.rs_b));
		if (exe_dec.imm !== e.imm)
			report_mismatch(names[n], "imm", e.imm, exe_dec.imm);
		if (exe_dec.ctrl.wr_en !== e.wr_en)
			report_mismatch(names[n], "wr_en", 32'(e.wr_en), 32'(exe_dec.ctrl.wr_en));
		if (exe_dec.ctrl.sel_data !== e.sel_data)
			report_mismatch(names[n], "sel_data", 32'(e.sel_data), 32'(exe_dec.ctrl.sel_data));
		if (exe_dec.is_comp !== e.is_comp)
			report_mismatch(names[n], "is_comp", 32'(e.is_comp), 32'(exe_dec.is_comp));
		if (exe_dec.illegal !== e.illegal)
			report_mismatch(names[n], "illegal", 32'(e.illegal), 32'(exe_dec.illegal));
		if (exe_pc4 !== e.pc4)
			report_mismatch(names[n], "pc4", 32'(e.pc4), 32'(exe_pc4));
		if (exe_target !== e.target)
			report_mismatch(names[n], "target", 32'(e.target), 32'(exe_target));
	endtask

	// Runaway guard
	initial begin
		wait (limit != 0);
		while (cycles < limit) begin
			@(posedge CLK);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d clock cycles", limit);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int gap;
		rst_n      = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		pc         = '0;
		rs1_data   = '0;
		load_table();
		limit = vectors.size() * 5 + 40;
		repeat (8) @(posedge CLK);
		#1;
		checks++;
		if (exe_valid !== 1'b0)
			report_mismatch("reset", "exe_valid", 32'd0, 32'(exe_valid));
		if (exe_dec.ctrl.wr_en !== 1'b0)
			report_mismatch("reset", "wr_en", 32'd0, 32'(exe_dec.ctrl.wr_en));
		#1;
		rst_n = 1'b1;
		for (int i = 0; i < vectors.size(); i++) begin
			inst_valid = 1'b1;		// Drive 2 ns after the edge
			inst       = vectors[i].inst;
			pc         = vectors[i].pc;
			rs1_data   = vectors[i].rs1_data;
			@(posedge CLK);
			#1;
			check_outputs(i);		// One cycle of latency
			#1;
			inst_valid = 1'b0;
			draw_gap(gap);
			repeat (gap) begin
				@(posedge CLK);
				#1;
				checks++;
				if (exe_valid !== 1'b0)
					report_mismatch(names[i], "exe_valid idle", 32'd0, 32'(exe_valid));
				#1;
			end
		end
		@(posedge CLK);
		#1;
		checks++;
		if (exe_valid !== 1'b0)
			report_mismatch("drain", "exe_valid", 32'd0, 32'(exe_valid));
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- decode_stage.f
design/decode_pkg.sv
design/base_decoder.sv
design/compressed_decoder.sv
design/decode_select.sv
design/decode_stage.sv
tests/decode_stage_checker.sv
tests/decode_stage_tb.sv

//--- Makefile
TOP             ?= decode_stage_tb
SIM_DIR         ?= obj_dir
FILE_LIST       ?= decode_stage.f
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --assert -j 0
LOG             ?= $(SIM_DIR)/sim.log

SOURCES := $(filter %.sv %.v,$(shell cat $(FILE_LIST)))
SIM_BIN := $(SIM_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(SIM_DIR)
